//--- Bender.yml
package:
  name: rv_decode

sources:
  - files:
      - logic/rv_decode_pkg.sv
      - logic/id_bundle_if.sv
      - logic/reg_file.sv
      - logic/imm_gen.sv
      - logic/id_control.sv
      - logic/target_gen.sv
      - logic/id_stage.sv
      - logic/decode_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_clock.sv
      - verif/tb_decode.sv

//--- list.f
+incdir+verif
logic/rv_decode_pkg.sv
logic/id_bundle_if.sv
logic/reg_file.sv
logic/imm_gen.sv
logic/id_control.sv
logic/target_gen.sv
logic/id_stage.sv
logic/decode_top.sv
verif/tb_clock.sv
verif/tb_decode.sv

//--- logic/decode_top.sv
`timescale 1ns/100ps

module decode_top #(
    parameter int BOOT_SEL_BIT = 30 // PC bit that selects the boot ROM
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  rv_decode_pkg::word_t if_pc,
    input  rv_decode_pkg::word_t if_bios_inst,
    input  rv_decode_pkg::word_t if_imem_inst,
    input  logic                 wb_regwen,
    input  rv_decode_pkg::word_t ex_alu,
    input  rv_decode_pkg::word_t ex_inst,
    input  rv_decode_pkg::word_t mem_alu,
    input  rv_decode_pkg::word_t mem_inst,
    input  rv_decode_pkg::word_t wb_wdata,
    input  rv_decode_pkg::word_t wb_inst,
    output rv_decode_pkg::word_t id_pc_target,
    output logic                 id_target_taken,
    output logic                 id_br_taken,
    output rv_decode_pkg::word_t id_pc,
    output rv_decode_pkg::word_t id_rd1,
    output rv_decode_pkg::word_t id_rd2,
    output rv_decode_pkg::word_t id_imm,
    output rv_decode_pkg::word_t id_inst
);

    id_stage #(
        .BOOT_SEL_BIT (BOOT_SEL_BIT)
    ) i_id_stage (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .flush           (flush),
        .if_pc           (if_pc),
        .if_bios_inst    (if_bios_inst),
        .if_imem_inst    (if_imem_inst),
        .wb_regwen       (wb_regwen),
        .ex_alu          (ex_alu),
        .ex_inst         (ex_inst),
        .mem_alu         (mem_alu),
        .mem_inst        (mem_inst),
        .wb_wdata        (wb_wdata),
        .wb_inst         (wb_inst),
        .id_pc_target    (id_pc_target),
        .id_target_taken (id_target_taken),
        .id_br_taken     (id_br_taken),
        .id_pc           (id_pc),
        .id_rd1          (id_rd1),
        .id_rd2          (id_rd2),
        .id_imm          (id_imm),
        .id_inst         (id_inst)
    );

endmodule

//--- logic/id_bundle_if.sv
`timescale 1ns/100ps

interface id_bundle_if;
    import rv_decode_pkg::*;

    word_t pc;
    word_t rd1;
    word_t rd2;
    word_t imm;
    inst_t inst;

    // Decode logic side
    modport source (
        output pc, rd1, rd2, imm, inst
    );

    // ID pipeline register side
    modport sink (
        input pc, rd1, rd2, imm, inst
    );

endinterface

//--- logic/id_control.sv
`timescale 1ns/100ps

module id_control (
    input  rv_decode_pkg::inst_t       inst,
    output rv_decode_pkg::imm_sel_e    imm_sel,
    output rv_decode_pkg::target_sel_e target_sel
);
    import rv_decode_pkg::*;

    // Only JALR reads rs1 for its target, so TGT_JALR also marks rs1 use
    always_comb begin
        imm_sel    = IMM_NONE;
        target_sel = TGT_NONE;
        case (inst.r_fmt.opcode)
            LUI,
            AUIPC: begin
                imm_sel = IMM_U;
            end
            JAL: begin
                imm_sel    = IMM_J;
                target_sel = TGT_JAL;
            end
            JALR: begin
                imm_sel    = IMM_I;
                target_sel = TGT_JALR;
            end
            BRANCH: begin
                imm_sel    = IMM_B;
                target_sel = TGT_BRANCH; // Predicted in this stage
            end
            LOAD,
            OP_IMM: begin
                imm_sel = IMM_I;
            end
            STORE: begin
                imm_sel = IMM_S;
            end
            OP: begin
                imm_sel = IMM_NONE; // Both operands from registers
            end
            default: begin
                imm_sel    = IMM_NONE;
                target_sel = TGT_NONE;
            end
        endcase
    end

endmodule

//--- logic/id_stage.sv
`timescale 1ns/100ps

module id_stage #(
    parameter int BOOT_SEL_BIT = 30
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  rv_decode_pkg::word_t if_pc,
    input  rv_decode_pkg::word_t if_bios_inst,
    input  rv_decode_pkg::word_t if_imem_inst,
    input  logic                 wb_regwen,
    input  rv_decode_pkg::word_t ex_alu,   // Forwarded for jalr
    input  rv_decode_pkg::word_t ex_inst,
    input  rv_decode_pkg::word_t mem_alu,
    input  rv_decode_pkg::word_t mem_inst,
    input  rv_decode_pkg::word_t wb_wdata, // Also the register file write data
    input  rv_decode_pkg::word_t wb_inst,
    output rv_decode_pkg::word_t id_pc_target,
    output logic                 id_target_taken,
    output logic                 id_br_taken,
    output rv_decode_pkg::word_t id_pc,
    output rv_decode_pkg::word_t id_rd1,
    output rv_decode_pkg::word_t id_rd2,
    output rv_decode_pkg::word_t id_imm,
    output rv_decode_pkg::word_t id_inst
);
    import rv_decode_pkg::*;

    imm_sel_e    imm_sel;
    target_sel_e target_sel;
    inst_t       wb_dec;

    id_bundle_if dec_bus ();

    // Boot ROM lives in the upper address region
    assign dec_bus.inst = if_pc[BOOT_SEL_BIT] ? if_bios_inst : if_imem_inst;
    assign dec_bus.pc   = if_pc;
    assign wb_dec       = wb_inst;

    reg_file i_reg_file (
        .clk   (clk),
        .reset (reset),
        .we    (wb_regwen),
        .ra1   (dec_bus.inst.r_fmt.rs1),
        .ra2   (dec_bus.inst.r_fmt.rs2),
        .wa    (wb_dec.r_fmt.rd),
        .wd    (wb_wdata),
        .rd1   (dec_bus.rd1),
        .rd2   (dec_bus.rd2)
    );

    id_control i_id_control (
        .inst       (dec_bus.inst),
        .imm_sel    (imm_sel),
        .target_sel (target_sel)
    );

    imm_gen i_imm_gen (
        .inst (dec_bus.inst),
        .sel  (imm_sel),
        .imm  (dec_bus.imm)
    );

    target_gen i_target_gen (
        .pc           (if_pc),
        .imm          (dec_bus.imm),
        .target_sel   (target_sel),
        .rs1_addr     (dec_bus.inst.r_fmt.rs1),
        .rf_rs1       (dec_bus.rd1),
        .ex_alu       (ex_alu),
        .ex_inst      (ex_inst),
        .mem_alu      (mem_alu),
        .mem_inst     (mem_inst),
        .wb_wdata     (wb_wdata),
        .wb_inst      (wb_inst),
        .target       (id_pc_target),
        .target_taken (id_target_taken),
        .br_taken     (id_br_taken)
    );

    // ID/EX pipeline register, flush beats stall
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            id_pc   <= '0;
            id_rd1  <= '0;
            id_rd2  <= '0;
            id_imm  <= '0;
            id_inst <= NOP_INST; // Bubble
        end else if (!stall) begin
            id_pc   <= dec_bus.pc;
            id_rd1  <= dec_bus.rd1;
            id_rd2  <= dec_bus.rd2;
            id_imm  <= dec_bus.imm;
            id_inst <= dec_bus.inst;
        end
    end

endmodule

//--- logic/imm_gen.sv
`timescale 1ns/100ps

module imm_gen (
    input  rv_decode_pkg::inst_t    inst,
    input  rv_decode_pkg::imm_sel_e sel,
    output rv_decode_pkg::word_t    imm
);
    import rv_decode_pkg::*;

    always_comb begin
        case (sel)
            IMM_I: imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            IMM_S: imm = {{20{inst.s_fmt.imm_11_5[6]}},
                          inst.s_fmt.imm_11_5,
                          inst.s_fmt.imm_4_0};
            IMM_B: imm = {{19{inst.b_fmt.imm_12}},
                          inst.b_fmt.imm_12,
                          inst.b_fmt.imm_11,
                          inst.b_fmt.imm_10_5,
                          inst.b_fmt.imm_4_1,
                          1'b0}; // Branch offsets are halfword aligned
            IMM_U: imm = {inst.u_fmt.imm_31_12, 12'b0};
            IMM_J: imm = {{11{inst.j_fmt.imm_20}},
                          inst.j_fmt.imm_20,
                          inst.j_fmt.imm_19_12,
                          inst.j_fmt.imm_11,
                          inst.j_fmt.imm_10_1,
                          1'b0};
            IMM_NONE: imm = '0; // R-type has no immediate
            default: imm = '0;
        endcase
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 we,
    input  logic [4:0]           ra1,
    input  logic [4:0]           ra2,
    input  logic [4:0]           wa,
    input  rv_decode_pkg::word_t wd,
    output rv_decode_pkg::word_t rd1,
    output rv_decode_pkg::word_t rd2
);
    import rv_decode_pkg::*;

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle writeback is bypassed onto the read ports
    always_comb begin
        if (ra1 == 5'd0)
            rd1 = '0;
        else if (we && (wa == ra1))
            rd1 = wd;
        else
            rd1 = regs[ra1];

        if (ra2 == 5'd0)
            rd2 = '0;
        else if (we && (wa == ra2))
            rd2 = wd;
        else
            rd2 = regs[ra2];
    end

endmodule

//--- logic/rv_decode_pkg.sv
package rv_decode_pkg;

    typedef logic [31:0] word_t;

    // RV32I major opcodes seen by the decode stage
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One instruction word viewed through each encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_NONE} imm_sel_e;

    typedef enum logic [1:0] {TGT_NONE, TGT_JAL, TGT_JALR, TGT_BRANCH} target_sel_e;

    localparam word_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0

endpackage

//--- logic/target_gen.sv
`timescale 1ns/100ps

module target_gen (
    input  rv_decode_pkg::word_t       pc,
    input  rv_decode_pkg::word_t       imm,
    input  rv_decode_pkg::target_sel_e target_sel,
    input  logic [4:0]                 rs1_addr,
    input  rv_decode_pkg::word_t       rf_rs1,
    input  rv_decode_pkg::word_t       ex_alu,
    input  rv_decode_pkg::inst_t       ex_inst,
    input  rv_decode_pkg::word_t       mem_alu,
    input  rv_decode_pkg::inst_t       mem_inst,
    input  rv_decode_pkg::word_t       wb_wdata,
    input  rv_decode_pkg::inst_t       wb_inst,
    output rv_decode_pkg::word_t       target,
    output logic                       target_taken,
    output logic                       br_taken
);
    import rv_decode_pkg::*;

    word_t rs1_val;
    word_t jalr_sum;

    // True when the older instruction writes the register that jalr reads
    function automatic logic fwd_hit(inst_t src, logic [4:0] addr);
        logic writes_rd;
        writes_rd = (src.r_fmt.opcode != BRANCH) && (src.r_fmt.opcode != STORE);
        return writes_rd && (src.r_fmt.rd != 5'd0) && (src.r_fmt.rd == addr);
    endfunction

    // Youngest producer wins
    always_comb begin
        if (fwd_hit(ex_inst, rs1_addr))
            rs1_val = ex_alu;
        else if (fwd_hit(mem_inst, rs1_addr))
            rs1_val = mem_alu;
        else if (fwd_hit(wb_inst, rs1_addr))
            rs1_val = wb_wdata;
        else
            rs1_val = rf_rs1;
    end

    assign jalr_sum = rs1_val + imm;

    always_comb begin
        target       = pc + 32'd4;
        target_taken = 1'b0;
        br_taken     = 1'b0;
        case (target_sel)
            TGT_JAL: begin
                target       = pc + imm;
                target_taken = 1'b1;
            end
            TGT_JALR: begin
                target       = {jalr_sum[31:1], 1'b0};
                target_taken = 1'b1;
            end
            TGT_BRANCH: begin
                if (imm[31]) begin // Backward branch predicted taken
                    target       = pc + imm;
                    target_taken = 1'b1;
                    br_taken     = 1'b1;
                end
            end
            default: ; // Fall through to pc + 4
        endcase
    end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0; // Released just after the edge, like the other inputs
    end

endmodule

//--- verif/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Sign-extended immediate straight from the RV32I encoding tables
function automatic word_t ref_imm(word_t w);
    case (w[6:0])
        LOAD, OP_IMM, JALR: return {{20{w[31]}}, w[31:20]};
        STORE:              return {{20{w[31]}}, w[31:25], w[11:7]};
        BRANCH:             return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        LUI, AUIPC:         return {w[31:12], 12'h000};
        JAL:                return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        default:            return 32'h0;
    endcase
endfunction

// Bit 1 is target_taken, bit 0 is br_taken
function automatic logic [1:0] ref_pred(word_t w, word_t imm);
    if (w[6:0] == JAL || w[6:0] == JALR)
        return 2'b10;
    if (w[6:0] == BRANCH && imm[31])
        return 2'b11; // Backward branch
    return 2'b00;
endfunction

function automatic logic writes_to(word_t src, logic [4:0] addr);
    return (src[6:0] != BRANCH) && (src[6:0] != STORE) && (src[11:7] != 5'd0)
        && (src[11:7] == addr);
endfunction

function automatic word_t ref_target(word_t pc, word_t w, word_t imm, word_t rf_rs1,
                                     word_t ex_alu, word_t ex_w, word_t mem_alu,
                                     word_t mem_w, word_t wb_data, word_t wb_w);
    word_t rs1;
    logic [1:0] pred;
    rs1 = rf_rs1;
    if (writes_to(wb_w, w[19:15])) rs1 = wb_data;
    if (writes_to(mem_w, w[19:15])) rs1 = mem_alu;
    if (writes_to(ex_w, w[19:15])) rs1 = ex_alu; // Youngest applied last
    pred = ref_pred(w, imm);
    if (w[6:0] == JALR)
        return (rs1 + imm) & ~32'h1;
    if (pred[1])
        return pc + imm;
    return pc + 32'd4;
endfunction

`endif

//--- verif/tb_decode.sv
`timescale 1ns/100ps

module tb_decode;
    import rv_decode_pkg::*;

    `include "tb_ref.svh"

    localparam int BOOT_BIT    = 30;
    localparam int CYCLE_LIMIT = 2 + 6 + 64 + 200 + 150 + 8 + 100 + 40 + 6 * 2 + 50;

    logic  clk, reset, stall, flush, wb_regwen;
    word_t if_pc, if_bios_inst, if_imem_inst, ex_alu, ex_inst, mem_alu, mem_inst;
    word_t wb_wdata, wb_inst;
    word_t id_pc_target, id_pc, id_rd1, id_rd2, id_imm, id_inst;
    logic  id_target_taken, id_br_taken;

    word_t   model_regs [32];
    word_t   exp_pc, exp_rd1, exp_rd2, exp_imm;
    inst_t   exp_inst;
    logic    exp_valid = 1'b0;
    int      err_count = 0;
    int      check_count = 0;
    int      test_start_errs = 0;
    int      cycle_count = 0;
    word_t   rng_state = 32'd85589;
    opcode_e all_ops [9] = '{LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, OP_IMM, OP};
    opcode_e src_ops [5] = '{OP, OP_IMM, LOAD, STORE, BRANCH};

    tb_clock i_tb_clock (.clk(clk), .reset(reset));

    decode_top #(.BOOT_SEL_BIT(BOOT_BIT)) i_decode_top (.*);

    function automatic word_t next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic word_t make_inst(opcode_e op);
        word_t r;
        r = next_rand();
        return {r[31:7], op};
    endfunction

    function automatic word_t insert_reg(word_t w, int lsb, logic [4:0] r);
        w[lsb +: 5] = r;
        return w;
    endfunction

    function automatic word_t rand_pc();
        return next_rand() & 32'h7fff_fffc;
    endfunction

    // Register file view with the same-cycle writeback bypass
    function automatic word_t read_model(logic [4:0] a);
        if (a == 5'd0)
            return 32'h0;
        if (wb_regwen && wb_inst[11:7] == a)
            return wb_wdata;
        return model_regs[a];
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_inst(string name, inst_t got, inst_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Registered outputs against last cycle's prediction, then this cycle's combinational outputs
    always @(negedge clk) begin : compare
        word_t cur;
        word_t imm_val;
        logic [1:0] pred;
        if (exp_valid) begin
            check_word("id_pc", id_pc, exp_pc);
            check_word("id_rd1", id_rd1, exp_rd1);
            check_word("id_rd2", id_rd2, exp_rd2);
            check_word("id_imm", id_imm, exp_imm);
            check_inst("id_inst", id_inst, exp_inst);
        end
        cur     = if_pc[BOOT_BIT] ? if_bios_inst : if_imem_inst;
        imm_val = ref_imm(cur);
        pred    = ref_pred(cur, imm_val);
        if (!reset) begin
            check_word("id_pc_target", id_pc_target,
                       ref_target(if_pc, cur, imm_val, read_model(cur[19:15]), ex_alu, ex_inst,
                                  mem_alu, mem_inst, wb_wdata, wb_inst));
            check_bit("id_target_taken", id_target_taken, pred[1]);
            check_bit("id_br_taken", id_br_taken, pred[0]);
        end
        if (reset || flush) begin // Flush wins over stall
            exp_pc   = 32'h0;
            exp_rd1  = 32'h0;
            exp_rd2  = 32'h0;
            exp_imm  = 32'h0;
            exp_inst = NOP_INST;
        end else if (!stall) begin
            exp_pc   = if_pc;
            exp_rd1  = read_model(cur[19:15]);
            exp_rd2  = read_model(cur[24:20]);
            exp_imm  = imm_val;
            exp_inst = cur;
        end
        exp_valid = 1'b1;
        if (reset)
            model_regs = '{default: 32'h0};
        else if (wb_regwen && wb_inst[11:7] != 5'd0)
            model_regs[wb_inst[11:7]] = wb_wdata;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout, the run went past %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic fetch(word_t pc, word_t inst);
        if_pc = pc;
        if (pc[BOOT_BIT]) begin
            if_bios_inst = inst;
            if_imem_inst = next_rand(); // Unselected word is noise
        end else begin
            if_imem_inst = inst;
            if_bios_inst = next_rand();
        end
    endtask

    task automatic clear_sources();
        ex_inst   = NOP_INST;
        mem_inst  = NOP_INST;
        wb_inst   = NOP_INST;
        ex_alu    = 32'h0;
        mem_alu   = 32'h0;
        wb_wdata  = 32'h0;
        wb_regwen = 1'b0;
    endtask

    // Two more cycles so the last registered result gets compared
    task automatic finish_test(string name);
        step();
        step();
        $display("Test %s finished with %0d errors", name, err_count - test_start_errs);
        test_start_errs = err_count;
    endtask

    task automatic run_flush_test();
        repeat (3) begin
            fetch(rand_pc(), make_inst(OP_IMM));
            step();
        end
        stall = 1'b1;
        flush = 1'b1;
        fetch(rand_pc(), make_inst(LOAD));
        step();
        flush = 1'b0; // Stalled bubble holds
        step();
        stall = 1'b0;
        step();
        finish_test("reset_flush");
    endtask

    task automatic run_reg_test();
        for (int i = 0; i < 32; i++) begin
            wb_regwen = 1'b1;
            wb_inst   = insert_reg(make_inst(OP), 7, 5'(i));
            wb_wdata  = next_rand();
            fetch(rand_pc() & ~32'h4000_0000,
                  insert_reg(insert_reg(make_inst(OP), 15, 5'(i)), 20, 5'(i - 1)));
            step();
        end
        wb_regwen = 1'b0;
        for (int i = 0; i < 32; i++) begin
            fetch(rand_pc(), insert_reg(insert_reg(make_inst(OP), 15, 5'(i)), 20, 5'(31 - i)));
            step();
        end
        finish_test("regfile");
    endtask

    task automatic run_imm_test();
        repeat (200) begin
            fetch(rand_pc(), make_inst(all_ops[next_rand() % 9]));
            step();
        end
        finish_test("immediate");
    endtask

    // Small register range so EX, MEM and WB often hit rs1
    task automatic run_jump_test();
        word_t w;
        repeat (150) begin
            w = make_inst((next_rand() % 2 == 0) ? JAL : JALR);
            fetch(rand_pc(), insert_reg(w, 15, 5'(1 + next_rand() % 3)));
            ex_inst   = insert_reg(make_inst(src_ops[next_rand() % 5]), 7, 5'(next_rand() % 4));
            mem_inst  = insert_reg(make_inst(src_ops[next_rand() % 5]), 7, 5'(next_rand() % 4));
            wb_inst   = insert_reg(make_inst(src_ops[next_rand() % 5]), 7, 5'(next_rand() % 4));
            ex_alu    = next_rand();
            mem_alu   = next_rand();
            wb_wdata  = next_rand();
            wb_regwen = (next_rand() % 2 == 0);
            step();
        end
        // Every mix of EX, MEM and WB writing x2 under a jalr on x2
        for (int m = 0; m < 8; m++) begin
            fetch(rand_pc(), insert_reg(make_inst(JALR), 15, 5'd2));
            ex_inst   = insert_reg(make_inst(OP), 7, m[0] ? 5'd2 : 5'd3);
            mem_inst  = insert_reg(make_inst(LOAD), 7, m[1] ? 5'd2 : 5'd3);
            wb_inst   = insert_reg(make_inst(OP_IMM), 7, m[2] ? 5'd2 : 5'd3);
            ex_alu    = next_rand();
            mem_alu   = next_rand();
            wb_wdata  = next_rand();
            wb_regwen = 1'b1;
            step();
        end
        clear_sources();
        finish_test("jump");
    endtask

    task automatic run_branch_test();
        repeat (100) begin
            fetch(rand_pc(), make_inst(BRANCH));
            step();
        end
        finish_test("branch");
    endtask

    task automatic run_stall_test();
        word_t r;
        repeat (40) begin
            r     = next_rand();
            stall = r[0];
            flush = (r[3:1] == 3'd0);
            fetch(rand_pc(), make_inst(all_ops[next_rand() % 9]));
            step();
        end
        stall = 1'b0;
        flush = 1'b0;
        finish_test("stall");
    endtask

    initial begin
        stall        = 1'b0;
        flush        = 1'b0;
        if_pc        = 32'h0;
        if_bios_inst = NOP_INST;
        if_imem_inst = NOP_INST;
        clear_sources();
        @(negedge reset);
        run_flush_test();
        run_reg_test();
        run_imm_test();
        run_jump_test();
        run_branch_test();
        run_stall_test();
        $display("Checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
